/* periphSys.f */
common/busPkg.sv
common/periphPkg.sv
common/regBusIf.sv
uart/uartTx.sv
uart/uartRx.sv
design/dacSpi.sv
design/pwmGen.sv
design/periphRegs.sv
design/axiLiteSlave.sv
design/periphSys.sv
dv/periphSys_chk.sv
dv/periphSysTb.sv

/* dv/periphSysTb.sv */
/*
 * Directed testbench for periphSys with BAUD_DIV 8 and SPI_DIV 2
 * Inputs change on the falling edge, handshakes are taken at the rising edge
 */
module periphSysTb;
    timeunit 1ns;
    timeprecision 100ps;
    import busPkg::*;
    import periphPkg::*;

    localparam int BAUD_DIV = 8;
    localparam int SPI_DIV  = 2;
    localparam int CLK_NS   = 40;
    // Tests take roughly 2500 cycles, PWM windows dominate, about twice that allowed
    localparam int WATCHDOG_NS = 200_000;

    logic           clk = 1'b0;
    logic           rstN;
    addrT           awAddr;
    logic           awValid;
    dataT           wData;
    strbT           wStrb;
    logic           wValid;
    logic           bReady;
    addrT           arAddr;
    logic           arValid;
    logic           rReady;
    logic           rx;
    logic           awReady;
    logic           wReady;
    respT           bResp;
    logic           bValid;
    logic           arReady;
    dataT           rData;
    respT           rResp;
    logic           rValid;
    ledT            ioOut;
    logic           pwmOut;
    logic           dacMosi;
    logic           dacSclk;
    logic           dacSs;
    logic           tx;

    int mismatchCnt = 0;
    int otherErrCnt = 0;
    int seed        = 2787;
    int dacFrameCnt = 0;

    periphSys #(
        .BAUD_DIV (BAUD_DIV),
        .SPI_DIV  (SPI_DIV)
    ) u_dut (
        .clk, .rstN, .awAddr, .awValid, .wData, .wStrb, .wValid, .bReady,
        .arAddr, .arValid, .rReady, .rx, .awReady, .wReady, .bResp, .bValid,
        .arReady, .rData, .rResp, .rValid, .ioOut, .pwmOut, .dacMosi, .dacSclk,
        .dacSs, .tx
    );

    always #(CLK_NS / 2) clk = ~clk;

    // Every frame starts with a falling chip select
    always @(negedge dacSs) dacFrameCnt++;

    function automatic addrT regAddr(input regIdxT idx);
        return addrT'({idx, 2'b00});
    endfunction

    task automatic checkData(input string name, input dataT exp, input dataT act);
        if (act !== exp) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkResp(input string name, input respT exp, input respT act);
        if (act !== exp) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkByte(input string name, input uartByteT exp, input uartByteT act);
        if (act !== exp) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkLed(input string name, input ledT exp, input ledT act);
        if (act !== exp) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input int exp, input int act);
        if (act != exp) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    // Frame is command nibble, code, then eight zero bits
    task automatic checkDac(input string name, input logic [23:0] frame, input dacCodeT exp);
        if (frame[23:20] !== DAC_CMD) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s command expected %h, got %h",
                     $time, name, DAC_CMD, frame[23:20]);
        end
        if (frame[19:8] !== exp) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s code expected %h, got %h",
                     $time, name, exp, frame[19:8]);
        end
        if (frame[7:0] !== 8'h00) begin
            mismatchCnt++;
            $display("Mismatch at %0t ns: %s pad expected 00, got %h", $time, name, frame[7:0]);
        end
    endtask

    // Address and data offered together, response taken on bValid
    task automatic axiWrite(input addrT addr, input dataT data, input strbT strb,
                            output respT resp);
        @(negedge clk);
        awAddr  = addr;
        wData   = data;
        wStrb   = strb;
        awValid = 1'b1;
        wValid  = 1'b1;
        do @(posedge clk); while (!(awReady && wReady));
        @(negedge clk);
        awValid = 1'b0;
        wValid  = 1'b0;
        bReady  = 1'b1;
        do @(posedge clk); while (!bValid);
        resp = bResp;
        @(negedge clk);
        bReady = 1'b0;
    endtask

    task automatic axiRead(input addrT addr, output dataT data, output respT resp);
        @(negedge clk);
        arAddr  = addr;
        arValid = 1'b1;
        do @(posedge clk); while (!arReady);
        @(negedge clk);
        arValid = 1'b0;
        rReady  = 1'b1;
        do @(posedge clk); while (!rValid);
        data = rData;
        resp = rResp;
        @(negedge clk);
        rReady = 1'b0;
    endtask

    // Poll STATUS until one flag drops
    task automatic waitStatusClear(input int bitPos);
        dataT stat;
        respT resp;
        int   polls;
        polls = 0;
        do begin
            axiRead(regAddr(REG_STAT), stat, resp);
            polls++;
        end while (stat[bitPos] && polls < 100);
        if (stat[bitPos]) begin
            otherErrCnt++;
            $display("Error at %0t ns: status bit %0d still set after %0d polls",
                     $time, bitPos, polls);
        end
    endtask

    // 8N1 frame on rx, LSB first
    task automatic sendRxFrame(input uartByteT data);
        @(negedge clk);
        rx = 1'b0;
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk);
            rx = data[i];
        end
        repeat (BAUD_DIV) @(negedge clk);
        rx = 1'b1;
        repeat (BAUD_DIV) @(negedge clk);
    endtask

    // Samples each bit near its middle
    task automatic captureTx(output uartByteT data);
        @(negedge tx);
        repeat (BAUD_DIV / 2) @(negedge clk);
        if (tx !== 1'b0) begin
            otherErrCnt++;
            $display("Error at %0t ns: tx start bit did not stay low", $time);
        end
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk);
            data[i] = tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        if (tx !== 1'b1) begin
            otherErrCnt++;
            $display("Error at %0t ns: tx stop bit is not high", $time);
        end
    endtask

    // MOSI is stable across each rising SCL edge
    task automatic captureDac(output logic [23:0] frame);
        @(negedge dacSs);
        for (int i = 0; i < 24; i++) begin
            @(posedge dacSclk);
            frame = {frame[22:0], dacMosi};
        end
        wait (dacSs === 1'b1);
    endtask

    task automatic testReset();
        checkLed("ioOut", '0, ioOut);
        // tx, dacSs, dacSclk, pwmOut, bValid, rValid, awReady, wReady, arReady
        checkData("idle outputs", 32'h1C0,
                  dataT'({tx, dacSs, dacSclk, pwmOut, bValid, rValid, awReady, wReady,
                          arReady}));
    endtask

    task automatic testLed();
        strbT strbs [4] = '{4'hF, 4'h2, 4'h1, 4'hE};
        dataT wdata;
        dataT rdata;
        respT resp;
        ledT  expLed;
        expLed = '0;
        foreach (strbs[i]) begin
            wdata = $random(seed);
            axiWrite(regAddr(REG_LED), wdata, strbs[i], resp);
            checkResp("bResp LED", RESP_OKAY, resp);
            // Only byte lane 0 holds LED bits
            if (strbs[i][0]) expLed = wdata[7:0];
            axiRead(regAddr(REG_LED), rdata, resp);
            checkResp("rResp LED", RESP_OKAY, resp);
            checkData("rData LED", dataT'(expLed), rdata);
            checkLed("ioOut", expLed, ioOut);
        end
    endtask

    task automatic testPwm();
        dutyT duties [3] = '{8'd0, 8'd77, 8'd255};
        respT resp;
        int   highCnt;
        foreach (duties[i]) begin
            axiWrite(regAddr(REG_PWM), dataT'(duties[i]), 4'h1, resp);
            checkResp("bResp PWM", RESP_OKAY, resp);
            // New duty takes effect at the next counter wrap
            repeat (260) @(negedge clk);
            highCnt = 0;
            repeat (256) begin
                @(negedge clk);
                if (pwmOut) highCnt++;
            end
            checkCount("pwmOut high cycles", int'(duties[i]), highCnt);
        end
    endtask

    task automatic testDac();
        dacCodeT     code;
        dataT        stat;
        respT        resp;
        logic [23:0] frame;
        int          framesBefore;
        code         = dacCodeT'($random(seed));
        framesBefore = dacFrameCnt;
        fork
            captureDac(frame);
            begin
                axiWrite(regAddr(REG_DAC), dataT'(code), 4'hF, resp);
                checkResp("bResp DAC", RESP_OKAY, resp);
                axiRead(regAddr(REG_STAT), stat, resp);
                checkData("STAT dacBusy", 32'h1, stat & 32'h1);
                // Refused while the frame is still going out
                axiWrite(regAddr(REG_DAC), dataT'(~code), 4'hF, resp);
                checkResp("bResp DAC while busy", RESP_SLVERR, resp);
            end
        join
        checkDac("DAC frame", frame, code);
        waitStatusClear(0);
        checkCount("DAC frames", framesBefore + 1, dacFrameCnt);
    endtask

    task automatic testUartTx();
        uartByteT sent;
        uartByteT got;
        respT     resp;
        repeat (2) begin
            sent = uartByteT'($random(seed));
            fork
                captureTx(got);
                begin
                    axiWrite(regAddr(REG_UTX), dataT'(sent), 4'hF, resp);
                    checkResp("bResp UTX", RESP_OKAY, resp);
                    axiWrite(regAddr(REG_UTX), dataT'(~sent), 4'hF, resp);
                    checkResp("bResp UTX while busy", RESP_SLVERR, resp);
                end
            join
            checkByte("tx frame", sent, got);
            waitStatusClear(1);
        end
    endtask

    task automatic testUartRx();
        uartByteT first;
        uartByteT second;
        dataT     rdata;
        respT     resp;
        first  = uartByteT'($random(seed));
        second = ~first;
        sendRxFrame(first);
        axiRead(regAddr(REG_STAT), rdata, resp);
        checkData("STAT rx flags", 32'h4, rdata & 32'hC);
        axiRead(regAddr(REG_URX), rdata, resp);
        checkResp("rResp URX", RESP_OKAY, resp);
        checkData("rData URX", 32'h100 | dataT'(first), rdata);
        axiRead(regAddr(REG_STAT), rdata, resp);
        checkData("STAT rx flags after read", 32'h0, rdata & 32'hC);
        // Later byte lands on the unread second byte
        sendRxFrame(second);
        sendRxFrame(first);
        axiRead(regAddr(REG_STAT), rdata, resp);
        checkData("STAT rx overrun", 32'hC, rdata & 32'hC);
        axiRead(regAddr(REG_URX), rdata, resp);
        checkData("rData URX after overrun", 32'h100 | dataT'(second), rdata);
        axiRead(regAddr(REG_STAT), rdata, resp);
        checkData("STAT rx flags cleared", 32'h0, rdata & 32'hC);
    endtask

    task automatic testDecode();
        addrT badAddrs [3] = '{8'h18, 8'h1C, 8'h40};
        dataT rdata;
        respT resp;
        foreach (badAddrs[i]) begin
            axiWrite(badAddrs[i], $random(seed), 4'hF, resp);
            checkResp("bResp unmapped", RESP_DECERR, resp);
            axiRead(badAddrs[i], rdata, resp);
            checkResp("rResp unmapped", RESP_DECERR, resp);
        end
        axiWrite(regAddr(REG_STAT), 32'hF, 4'hF, resp);
        checkResp("bResp STAT write", RESP_SLVERR, resp);
        axiWrite(regAddr(REG_URX), 32'hF, 4'hF, resp);
        checkResp("bResp URX write", RESP_SLVERR, resp);
    endtask

    initial begin
        rstN    = 1'b0;
        awAddr  = '0;
        awValid = 1'b0;
        wData   = '0;
        wStrb   = '0;
        wValid  = 1'b0;
        bReady  = 1'b0;
        arAddr  = '0;
        arValid = 1'b0;
        rReady  = 1'b0;
        rx      = 1'b1;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        testReset();
        testLed();
        testPwm();
        testDac();
        testDac();
        testUartTx();
        testUartRx();
        testDecode();
        $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatchCnt, otherErrCnt, u_dut.uChk.failCnt);
        if (mismatchCnt == 0 && otherErrCnt == 0 && u_dut.uChk.failCnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Error: timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Summary: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatchCnt, otherErrCnt + 1, u_dut.uChk.failCnt);
        $display("Checks failed");
        $finish;
    end

endmodule

/* dv/periphSys_chk.sv */
/*
 * Bus and pin protocol assertions bound into periphSys, idle during reset
 * Transmitter busy flag is taken from the register block instance
 */
module periphSys_chk (
    input logic          clk,
    input logic          rstN,
    input logic          bValid,
    input logic          bReady,
    input busPkg::respT  bResp,
    input logic          rValid,
    input logic          rReady,
    input busPkg::dataT  rData,
    input busPkg::respT  rResp,
    input logic          dacSclk,
    input logic          dacSs,
    input logic          tx,
    input logic          txBusy
);
    timeunit 1ns;
    timeprecision 100ps;

    // Number of failed assertions
    int failCnt = 0;

    // Write response held until taken
    assert property (@(posedge clk) disable iff (!rstN)
        bValid && !bReady |=> bValid && $stable(bResp))
        else begin
            failCnt++;
            $error("write response dropped or changed before bReady");
        end

    // Read response held until taken
    assert property (@(posedge clk) disable iff (!rstN)
        rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
        else begin
            failCnt++;
            $error("read response dropped or changed before rReady");
        end

    // Last SCL edge and rising SS share a clock edge
    assert property (@(posedge clk) disable iff (!rstN)
        $changed(dacSclk) |-> !$past(dacSs))
        else begin
            failCnt++;
            $error("dacSclk toggled while dacSs was high");
        end

    // Line idles high
    assert property (@(posedge clk) disable iff (!rstN)
        !txBusy |-> tx)
        else begin
            failCnt++;
            $error("tx low while the transmitter is idle");
        end

endmodule

bind periphSys periphSys_chk uChk (
    .clk, .rstN, .bValid, .bReady, .bResp, .rValid, .rReady, .rData, .rResp,
    .dacSclk, .dacSs, .tx, .txBusy (uRegs.txBusy)
);

/* design/periphSys.sv */
/*
 * Peripheral subsystem top, AXI4-Lite slave with one transaction in flight
 * BAUD_DIV is clocks per UART bit, SPI_DIV clocks per DAC SCL half period
 */
module periphSys #(
    parameter int BAUD_DIV = 8,
    parameter int SPI_DIV  = 2
) (
    input  logic             clk,
    input  logic             rstN,
    input  busPkg::addrT     awAddr,
    input  logic             awValid,
    input  busPkg::dataT     wData,
    input  busPkg::strbT     wStrb,
    input  logic             wValid,
    input  logic             bReady,
    input  busPkg::addrT     arAddr,
    input  logic             arValid,
    input  logic             rReady,
    input  logic             rx,
    output logic             awReady,
    output logic             wReady,
    output busPkg::respT     bResp,
    output logic             bValid,
    output logic             arReady,
    output busPkg::dataT     rData,
    output busPkg::respT     rResp,
    output logic             rValid,
    output periphPkg::ledT   ioOut,
    output logic             pwmOut,
    output logic             dacMosi,
    output logic             dacSclk,
    output logic             dacSs,
    output logic             tx
);

    // Register access channel
    regBusIf uBus ();

    axiLiteSlave uAxi (
        .clk,
        .rstN,
        .awAddr,
        .awValid,
        .wData,
        .wStrb,
        .wValid,
        .bReady,
        .arAddr,
        .arValid,
        .rReady,
        .awReady,
        .wReady,
        .bResp,
        .bValid,
        .arReady,
        .rData,
        .rResp,
        .rValid,
        .bus     (uBus)
    );

    periphRegs #(
        .BAUD_DIV (BAUD_DIV),
        .SPI_DIV  (SPI_DIV)
    ) uRegs (
        .clk,
        .rstN,
        .bus     (uBus),
        .rx,
        .ioOut,
        .pwmOut,
        .dacMosi,
        .dacSclk,
        .dacSs,
        .tx
    );

endmodule

/* design/axiLiteSlave.sv */
/*
 * AXI4-Lite slave, one outstanding transaction, write wins over read
 * Addresses at or above 0x20 get DECERR without touching the registers
 */
module axiLiteSlave (
    input  logic          clk,
    input  logic          rstN,
    input  busPkg::addrT  awAddr,
    input  logic          awValid,
    input  busPkg::dataT  wData,
    input  busPkg::strbT  wStrb,
    input  logic          wValid,
    input  logic          bReady,
    input  busPkg::addrT  arAddr,
    input  logic          arValid,
    input  logic          rReady,
    output logic          awReady,
    output logic          wReady,
    output busPkg::respT  bResp,
    output logic          bValid,
    output logic          arReady,
    output busPkg::dataT  rData,
    output busPkg::respT  rResp,
    output logic          rValid,
    regBusIf.ctrl         bus
);
    import busPkg::*;

    logic pending;
    logic wrAcc;
    logic rdAcc;
    logic inRange;
    addrT addrSel;
    respT resp;

    // Any response still waiting blocks new addresses
    assign pending = bValid | rValid;
    assign wrAcc   = awValid & wValid & ~pending;
    assign rdAcc   = arValid & ~awValid & ~pending | arValid & ~wValid & ~pending;

    assign awReady = wrAcc;
    assign wReady  = wrAcc;
    assign arReady = rdAcc;

    // Address of the accepted channel
    assign addrSel = wrAcc ? awAddr : arAddr;
    assign inRange = (addrSel[ADDR_W-1:5] == '0);

    // One register access per accepted transaction
    assign bus.req    = (wrAcc | rdAcc) & inRange;
    assign bus.write  = wrAcc;
    assign bus.idx    = addrSel[4:2];
    assign bus.wrData = wData;
    assign bus.wrStrb = wStrb;

    assign resp = inRange ? bus.err : RESP_DECERR;

    // Response handshake flags
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bValid <= 1'b0;
            rValid <= 1'b0;
        end else begin
            if (wrAcc) begin
                bValid <= 1'b1;
            end else if (bReady) begin
                bValid <= 1'b0;
            end
            if (rdAcc) begin
                rValid <= 1'b1;
            end else if (rReady) begin
                rValid <= 1'b0;
            end
        end
    end

    // Response payload, captured at acceptance
    always_ff @(posedge clk) begin
        if (wrAcc) begin
            bResp <= resp;
        end
        if (rdAcc) begin
            rResp <= resp;
            rData <= inRange ? bus.rdData : '0;
        end
    end

endmodule

/* design/periphRegs.sv */
/*
 * Register file and engine control, LED and duty use byte strobe 0 only
 * Write-only registers read as zero, busy engines refuse starts with SLVERR
 */
module periphRegs #(
    parameter int BAUD_DIV = 8,
    parameter int SPI_DIV  = 2
) (
    input  logic            clk,
    input  logic            rstN,
    regBusIf.regs           bus,
    input  logic            rx,
    output periphPkg::ledT  ioOut,
    output logic            pwmOut,
    output logic            dacMosi,
    output logic            dacSclk,
    output logic            dacSs,
    output logic            tx
);
    import busPkg::*;
    import periphPkg::*;

    ledT      ledR;
    dutyT     dutyR;
    uartByteT rxData;
    uartByteT rxByte;
    logic     rxValid;
    logic     rxOverrun;
    logic     rxDone;
    logic     ledWe;
    logic     dutyWe;
    logic     dacStart;
    logic     txStart;
    logic     urxRead;
    logic     dacBusy;
    logic     txBusy;

    // Decode, read mux and start pulses
    always_comb begin
        bus.rdData = '0;
        bus.err    = RESP_OKAY;
        ledWe      = 1'b0;
        dutyWe     = 1'b0;
        dacStart   = 1'b0;
        txStart    = 1'b0;
        urxRead    = 1'b0;
        case (bus.idx)
            REG_LED: begin
                bus.rdData = dataT'(ledR);
                ledWe      = bus.req & bus.write & bus.wrStrb[0];
            end
            REG_PWM: begin
                bus.rdData = dataT'(dutyR);
                dutyWe     = bus.req & bus.write & bus.wrStrb[0];
            end
            REG_DAC: begin
                if (bus.write && dacBusy) bus.err = RESP_SLVERR;
                else dacStart = bus.req & bus.write;
            end
            REG_UTX: begin
                if (bus.write && txBusy) bus.err = RESP_SLVERR;
                else txStart = bus.req & bus.write;
            end
            REG_URX: begin
                bus.rdData = {23'b0, rxValid, rxData};
                if (bus.write) bus.err = RESP_SLVERR;
                else urxRead = bus.req;
            end
            REG_STAT: begin
                bus.rdData = {28'b0, rxOverrun, rxValid, txBusy, dacBusy};
                if (bus.write) bus.err = RESP_SLVERR;
            end
            default: bus.err = RESP_DECERR;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ledR      <= '0;
            dutyR     <= '0;
            rxData    <= '0;
            rxValid   <= 1'b0;
            rxOverrun <= 1'b0;
        end else begin
            if (ledWe) ledR <= bus.wrData[7:0];
            if (dutyWe) dutyR <= bus.wrData[7:0];
            // New byte while the old one is unread keeps the old one
            if (rxDone) begin
                if (rxValid && !urxRead) begin
                    rxOverrun <= 1'b1;
                end else begin
                    rxData    <= rxByte;
                    rxValid   <= 1'b1;
                    rxOverrun <= 1'b0;
                end
            end else if (urxRead) begin
                rxValid   <= 1'b0;
                rxOverrun <= 1'b0;
            end
        end
    end

    assign ioOut = ledR;

    dacSpi #(.SPI_DIV(SPI_DIV)) uDac (
        .clk, .rstN, .start(dacStart), .code(bus.wrData[11:0]),
        .busy(dacBusy), .dacMosi, .dacSclk, .dacSs
    );

    pwmGen uPwm (.clk, .rstN, .duty(dutyR), .pwmOut);

    uartTx #(.BAUD_DIV(BAUD_DIV)) uTx (
        .clk, .rstN, .start(txStart), .data(bus.wrData[7:0]), .busy(txBusy), .tx
    );

    uartRx #(.BAUD_DIV(BAUD_DIV)) uRx (
        .clk, .rstN, .rx, .valid(rxDone), .data(rxByte)
    );

endmodule

/* design/pwmGen.sv */
/*
 * 256-step PWM, duty is taken at the counter wrap
 * Output high for exactly duty cycles out of every 256
 */
module pwmGen (
    input  logic             clk,
    input  logic             rstN,
    input  periphPkg::dutyT  duty,
    output logic             pwmOut
);
    import periphPkg::*;

    logic [7:0] cnt;
    dutyT       dutyR;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt   <= '0;
            dutyR <= '0;
        end else begin
            cnt <= cnt + 8'd1;
            // Reload only between windows
            if (cnt == 8'hFF) dutyR <= duty;
        end
    end

    assign pwmOut = (cnt < dutyR);

endmodule

/* design/dacSpi.sv */
/*
 * AD5681R frame writer, 24 bits MSB first, SCL idles high
 * MOSI changes on SCL fall, frame takes 48*SPI_DIV+2 cycles from start
 */
module dacSpi #(
    parameter int SPI_DIV = 2
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  periphPkg::dacCodeT  code,
    output logic                busy,
    output logic                dacMosi,
    output logic                dacSclk,
    output logic                dacSs
);
    import periphPkg::*;

    localparam int DIV_W = $clog2(SPI_DIV + 1);

    spiStateT          state;
    logic [DIV_W-1:0]  divCnt;
    logic [4:0]        bitCnt;
    logic [23:0]       shiftReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= SPI_IDLE;
            divCnt   <= '0;
            bitCnt   <= '0;
            shiftReg <= '0;
            dacSclk  <= 1'b1;
            dacSs    <= 1'b1;
        end else begin
            case (state)
                SPI_IDLE: if (start) begin
                    state    <= SPI_SHIFT;
                    dacSs    <= 1'b0;
                    shiftReg <= {DAC_CMD, code, 8'h00};
                    divCnt   <= '0;
                    bitCnt   <= '0;
                end
                SPI_SHIFT: begin
                    if (divCnt == DIV_W'(SPI_DIV - 1)) begin
                        divCnt  <= '0;
                        dacSclk <= ~dacSclk;
                        if (dacSclk) begin
                            // Falling edge, first bit is already on MOSI
                            if (bitCnt != 5'd0) shiftReg <= shiftReg << 1;
                        end else begin
                            bitCnt <= bitCnt + 5'd1;
                            if (bitCnt == 5'd23) begin
                                state <= SPI_DONE;
                                dacSs <= 1'b1;
                            end
                        end
                    end else begin
                        divCnt <= divCnt + 1'b1;
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    assign busy    = (state != SPI_IDLE);
    assign dacMosi = shiftReg[23];

endmodule

/* uart/uartRx.sv */
/*
 * 8N1 receiver, rx is asynchronous and goes through two flops
 * Bits are sampled mid-bit, frames with a low stop bit are dropped
 */
module uartRx #(
    parameter int BAUD_DIV = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 rx,
    output logic                 valid,
    output periphPkg::uartByteT  data
);
    import periphPkg::*;

    localparam int CNT_W = $clog2(BAUD_DIV + 1);

    rxStateT          state;
    logic [2:0]       rxSync;
    logic [CNT_W-1:0] baudCnt;
    logic [2:0]       bitCnt;
    logic             rxS;
    logic             bitEnd;

    // Synchronized line, bit 2 is one cycle older for edge detect
    assign rxS    = rxSync[1];
    assign bitEnd = (baudCnt == CNT_W'(BAUD_DIV - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxSync  <= 3'b111;
            state   <= RX_IDLE;
            baudCnt <= '0;
            bitCnt  <= '0;
            data    <= '0;
            valid   <= 1'b0;
        end else begin
            rxSync  <= {rxSync[1:0], rx};
            valid   <= 1'b0;
            baudCnt <= bitEnd ? '0 : baudCnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baudCnt <= '0;
                    if (rxSync[2] && !rxS) state <= RX_START;
                end
                RX_START: if (baudCnt == CNT_W'(BAUD_DIV / 2 - 1)) begin
                    // Mid start bit, restart the bit timer here
                    baudCnt <= '0;
                    bitCnt  <= '0;
                    state   <= rxS ? RX_IDLE : RX_DATA;
                end
                RX_DATA: if (bitEnd) begin
                    data <= {rxS, data[7:1]};
                    if (bitCnt == 3'd7) state <= RX_STOP;
                    bitCnt <= bitCnt + 3'd1;
                end
                default: if (bitEnd) begin
                    state <= RX_IDLE;
                    valid <= rxS;
                end
            endcase
        end
    end

endmodule

/* uart/uartTx.sv */
/*
 * 8N1 transmitter, LSB first, BAUD_DIV clocks per bit
 * start is ignored while busy, tx idles high
 */
module uartTx #(
    parameter int BAUD_DIV = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  periphPkg::uartByteT  data,
    output logic                 busy,
    output logic                 tx
);
    import periphPkg::*;

    localparam int CNT_W = $clog2(BAUD_DIV + 1);

    txStateT          state;
    logic [CNT_W-1:0] baudCnt;
    logic [2:0]       bitCnt;
    uartByteT         shReg;
    logic             bitEnd;

    assign bitEnd = (baudCnt == CNT_W'(BAUD_DIV - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= TX_IDLE;
            baudCnt <= '0;
            bitCnt  <= '0;
            shReg   <= '0;
            tx      <= 1'b1;
        end else begin
            baudCnt <= (state == TX_IDLE || bitEnd) ? '0 : baudCnt + 1'b1;
            case (state)
                TX_IDLE: if (start) begin
                    state <= TX_START;
                    shReg <= data;
                    tx    <= 1'b0;
                end
                TX_START: if (bitEnd) begin
                    state  <= TX_DATA;
                    bitCnt <= '0;
                    tx     <= shReg[0];
                end
                TX_DATA: if (bitEnd) begin
                    if (bitCnt == 3'd7) begin
                        state <= TX_STOP;
                        tx    <= 1'b1;
                    end else begin
                        bitCnt <= bitCnt + 3'd1;
                        shReg  <= shReg >> 1;
                        tx     <= shReg[1];
                    end
                end
                default: if (bitEnd) state <= TX_IDLE;
            endcase
        end
    end

    assign busy = (state != TX_IDLE);

endmodule

/* common/regBusIf.sv */
/*
 * Single-cycle register access between the bus front end and the registers
 * err carries a full AXI response code, answered in the same cycle as req
 */
interface regBusIf;
    import busPkg::*;
    import periphPkg::*;

    // Request side
    logic   req;
    logic   write;
    regIdxT idx;
    dataT   wrData;
    strbT   wrStrb;

    // Combinational answer
    dataT   rdData;
    respT   err;

    modport ctrl (output req, write, idx, wrData, wrStrb, input rdData, err);
    modport regs (input req, write, idx, wrData, wrStrb, output rdData, err);

endinterface

/* common/periphPkg.sv */
/*
 * Peripheral register map, data types and engine FSM states
 * Word index is address bits 4:2, indices 6 and 7 are unmapped
 */
package periphPkg;

    typedef logic [2:0]  regIdxT;
    typedef logic [7:0]  ledT;
    typedef logic [7:0]  dutyT;
    typedef logic [11:0] dacCodeT;
    typedef logic [7:0]  uartByteT;

    // Register word indices
    localparam regIdxT REG_LED  = 3'd0;
    localparam regIdxT REG_PWM  = 3'd1;
    localparam regIdxT REG_DAC  = 3'd2;
    localparam regIdxT REG_UTX  = 3'd3;
    localparam regIdxT REG_URX  = 3'd4;
    localparam regIdxT REG_STAT = 3'd5;

    // AD5681R write and update command
    localparam logic [3:0] DAC_CMD = 4'b0011;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txStateT;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateT;
    typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spiStateT;

endpackage

/* common/busPkg.sv */
/*
 * AXI4-Lite bus types, 8-bit byte address and 32-bit data
 * Only OKAY, SLVERR and DECERR responses are ever produced
 */
package busPkg;

    // Byte address width of the register window
    localparam int ADDR_W = 8;

    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [31:0]       dataT;
    typedef logic [3:0]        strbT;
    typedef logic [1:0]        respT;

    // AXI response codes
    localparam respT RESP_OKAY   = 2'b00;
    localparam respT RESP_SLVERR = 2'b10;
    localparam respT RESP_DECERR = 2'b11;

endpackage
